/* source/rv_decode_macros.svh */
/*
 * Shared constants for the RV32I decode stage: data width,
 * register address width, reset PC and the major opcode encodings.
 */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

`define RV_XLEN             32              // Datapath width
`define RV_REG_AW           5               // Register index width

`define RV_RESET_PC         32'h1000_0000   // First fetch address

// Major opcodes, instr[6:0]
// ----------------------------------------
`define RV_OP_LOAD          7'b0000011
`define RV_OP_STORE         7'b0100011
`define RV_OP_IMM           7'b0010011
`define RV_OP_REG           7'b0110011
`define RV_OP_LUI           7'b0110111
`define RV_OP_AUIPC         7'b0010111
`define RV_OP_BRANCH        7'b1100011
`define RV_OP_JAL           7'b1101111
`define RV_OP_JALR          7'b1100111

`endif

/* source/rv_decode_pkg.sv */
/*
 * Types of the decode stage: data word and register index,
 * micro-op enums, and the structs passed between fetch, decode,
 * control flow and execute.
 */
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Micro-op classes
    // ----------------------------------------
    typedef enum logic [3:0] {
        alu_none, alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [3:0] {
        cfu_none, cfu_beq, cfu_bne, cfu_blt, cfu_bge,
        cfu_bltu, cfu_bgeu, cfu_jal, cfu_jalr
    } cfu_op_e;

    typedef enum logic [1:0] {lsu_none, lsu_load, lsu_store} lsu_op_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {lsu_byte, lsu_half, lsu_word} lsu_width_e;

    typedef enum logic [1:0] {wb_none, wb_alu, wb_lsu, wb_npc} wb_sel_e;

    typedef enum logic [2:0] {imm_none, imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

    // Stage interfaces
    // ----------------------------------------
    typedef struct packed {
        logic        valid;         // Instruction word present
        logic [31:0] instr;         // Raw instruction
        logic        ferr;          // Fetch bus error
    } fetch_t;

    typedef struct packed {
        logic  valid;               // Control flow change requested
        logic  ack;                 // Change accepted
        word_t target;              // New PC
    } cf_redirect_t;

    typedef struct packed {
        alu_op_e    alu_op;
        cfu_op_e    cfu_op;
        lsu_op_e    lsu_op;
        lsu_width_e lsu_width;
        logic       lsu_sext;       // Sign extend load data
        wb_sel_e    wb_sel;
        imm_fmt_e   imm_fmt;
        logic       rhs_imm;        // ALU rhs from immediate
        logic       lhs_pc;         // ALU lhs from PC
        logic       trap;
    } uop_t;

    typedef struct packed {
        word_t     pc;
        word_t     npc;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        word_t     alu_lhs;
        word_t     alu_rhs;
        uop_t      uop;
    } decode_out_t;

endpackage

`default_nettype wire

/* source/rv_imm_gen.sv */
/*
 * Immediate generator for the RV32I formats I, S, B, U and J.
 * Output is sign extended, U keeps its low 12 bits zero.
 */
`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen (
    input  wire [31:0]                  instr_i,    // Instruction word
    input  wire rv_decode_pkg::imm_fmt_e fmt_i,     // Format from decoder
    output rv_decode_pkg::word_t        imm_o       // Extended immediate
);

    logic sign;

    assign sign = instr_i[31];      // All formats share the sign bit

    always_comb begin
        case (fmt_i)
            rv_decode_pkg::imm_i: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
            rv_decode_pkg::imm_s: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_decode_pkg::imm_b: begin
                imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            rv_decode_pkg::imm_u: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            rv_decode_pkg::imm_j: begin
                imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;         // R-type and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_uop_decode.sv */
/*
 * RV32I micro-op decoder: opcode and funct fields to ALU, control
 * flow and load/store ops, register indices and the trap flag.
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_uop_decode (
    input  wire [31:0]              instr_i,    // Instruction word
    input  wire                     ferr_i,     // Fetch bus error
    output rv_decode_pkg::uop_t     uop_o,      // Decoded micro-op
    output rv_decode_pkg::reg_addr_t rs1_o,     // Source 1 index
    output rv_decode_pkg::reg_addr_t rs2_o,     // Source 2 index
    output rv_decode_pkg::reg_addr_t rd_o       // Destination index
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                zero_f7;
    logic                alt_f7;
    logic                illegal;
    logic                use_rs1;
    logic                use_rs2;
    logic                use_rd;
    rv_decode_pkg::uop_t uop;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign zero_f7 = funct7 == 7'b0000000;
    assign alt_f7  = funct7 == 7'b0100000;  // sub and sra

    // ALU op shared by OP and OP-IMM
    function automatic rv_decode_pkg::alu_op_e alu_sel(input logic [2:0] f3,
                                                       input logic       alt);
        case (f3)
            3'b000:  return alt ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
            3'b001:  return rv_decode_pkg::alu_sll;
            3'b010:  return rv_decode_pkg::alu_slt;
            3'b011:  return rv_decode_pkg::alu_sltu;
            3'b100:  return rv_decode_pkg::alu_xor;
            3'b101:  return alt ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
            3'b110:  return rv_decode_pkg::alu_or;
            default: return rv_decode_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        uop.alu_op    = rv_decode_pkg::alu_none;
        uop.cfu_op    = rv_decode_pkg::cfu_none;
        uop.lsu_op    = rv_decode_pkg::lsu_none;
        uop.lsu_width = rv_decode_pkg::lsu_byte;
        uop.lsu_sext  = 1'b0;
        uop.wb_sel    = rv_decode_pkg::wb_none;
        uop.imm_fmt   = rv_decode_pkg::imm_none;
        uop.rhs_imm   = 1'b0;
        uop.lhs_pc    = 1'b0;
        uop.trap      = 1'b0;
        illegal       = 1'b0;
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        use_rd        = 1'b0;

        case (opcode)
            `RV_OP_LOAD: begin
                uop.alu_op    = rv_decode_pkg::alu_add;     // Address calc
                uop.lsu_op    = rv_decode_pkg::lsu_load;
                uop.lsu_width = rv_decode_pkg::lsu_width_e'(funct3[1:0]);
                uop.lsu_sext  = !funct3[2];                 // lbu, lhu clear it
                uop.wb_sel    = rv_decode_pkg::wb_lsu;
                uop.imm_fmt   = rv_decode_pkg::imm_i;
                uop.rhs_imm   = 1'b1;
                use_rs1       = 1'b1;
                use_rd        = 1'b1;
                illegal       = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            `RV_OP_STORE: begin
                uop.alu_op    = rv_decode_pkg::alu_add;
                uop.lsu_op    = rv_decode_pkg::lsu_store;
                uop.lsu_width = rv_decode_pkg::lsu_width_e'(funct3[1:0]);
                uop.imm_fmt   = rv_decode_pkg::imm_s;
                uop.rhs_imm   = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                illegal       = funct3[2] || (funct3[1:0] == 2'b11);
            end
            `RV_OP_IMM: begin
                uop.alu_op  = alu_sel(funct3, (funct3 == 3'b101) && alt_f7);
                uop.wb_sel  = rv_decode_pkg::wb_alu;
                uop.imm_fmt = rv_decode_pkg::imm_i;
                uop.rhs_imm = 1'b1;
                use_rs1     = 1'b1;
                use_rd      = 1'b1;
                // Shift amounts leave only the srai marker in funct7
                illegal     = ((funct3 == 3'b001) && !zero_f7) ||
                              ((funct3 == 3'b101) && !zero_f7 && !alt_f7);
            end
            `RV_OP_REG: begin
                uop.alu_op = alu_sel(funct3, alt_f7);
                uop.wb_sel = rv_decode_pkg::wb_alu;
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                use_rd     = 1'b1;
                illegal    = !(zero_f7 ||
                               (alt_f7 && ((funct3 == 3'b000) || (funct3 == 3'b101))));
            end
            `RV_OP_LUI: begin
                uop.alu_op  = rv_decode_pkg::alu_or;        // x0 | imm
                uop.wb_sel  = rv_decode_pkg::wb_alu;
                uop.imm_fmt = rv_decode_pkg::imm_u;
                uop.rhs_imm = 1'b1;
                use_rd      = 1'b1;
            end
            `RV_OP_AUIPC: begin
                uop.alu_op  = rv_decode_pkg::alu_add;       // pc + imm
                uop.wb_sel  = rv_decode_pkg::wb_alu;
                uop.imm_fmt = rv_decode_pkg::imm_u;
                uop.rhs_imm = 1'b1;
                uop.lhs_pc  = 1'b1;
                use_rd      = 1'b1;
            end
            `RV_OP_BRANCH: begin
                uop.alu_op  = rv_decode_pkg::alu_sub;       // Compare operands
                uop.imm_fmt = rv_decode_pkg::imm_b;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                case (funct3)
                    3'b000:  uop.cfu_op = rv_decode_pkg::cfu_beq;
                    3'b001:  uop.cfu_op = rv_decode_pkg::cfu_bne;
                    3'b100:  uop.cfu_op = rv_decode_pkg::cfu_blt;
                    3'b101:  uop.cfu_op = rv_decode_pkg::cfu_bge;
                    3'b110:  uop.cfu_op = rv_decode_pkg::cfu_bltu;
                    3'b111:  uop.cfu_op = rv_decode_pkg::cfu_bgeu;
                    default: illegal    = 1'b1;
                endcase
            end
            `RV_OP_JAL: begin
                uop.cfu_op  = rv_decode_pkg::cfu_jal;
                uop.wb_sel  = rv_decode_pkg::wb_npc;        // Link address
                uop.imm_fmt = rv_decode_pkg::imm_j;
                use_rd      = 1'b1;
            end
            `RV_OP_JALR: begin
                uop.cfu_op  = rv_decode_pkg::cfu_jalr;
                uop.wb_sel  = rv_decode_pkg::wb_npc;
                uop.imm_fmt = rv_decode_pkg::imm_i;
                use_rs1     = 1'b1;
                use_rd      = 1'b1;
                illegal     = funct3 != 3'b000;
            end
            default: begin
                illegal = 1'b1;                             // Unknown opcode
            end
        endcase

        // A trapping instruction must not write back or change state
        uop.trap = illegal || ferr_i;
        if (uop.trap) begin
            uop.wb_sel = rv_decode_pkg::wb_none;
            uop.cfu_op = rv_decode_pkg::cfu_none;
            uop.lsu_op = rv_decode_pkg::lsu_none;
        end
    end

    assign uop_o = uop;
    assign rs1_o = use_rs1 ? instr_i[19:15] : '0;   // Unused ports read x0
    assign rs2_o = use_rs2 ? instr_i[24:20] : '0;
    assign rd_o  = use_rd  ? instr_i[11:7]  : '0;

endmodule

`default_nettype wire

/* source/rv_pc_track.sv */
/*
 * Program counter register: reset value, redirect load and
 * advance by one instruction on consume.
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_pc_track (
    input  wire                              g_clk,
    input  wire                              g_resetn,
    input  wire rv_decode_pkg::cf_redirect_t cf_i,      // Control flow change
    input  wire                              consume_i, // Instruction taken
    output rv_decode_pkg::word_t             pc_o,      // Current PC
    output rv_decode_pkg::word_t             npc_o      // PC of next instr
);

    rv_decode_pkg::word_t pc;
    logic                 redirect;

    assign redirect = cf_i.valid && cf_i.ack;
    assign npc_o    = pc + rv_decode_pkg::word_t'(4);  // 32-bit only

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `RV_RESET_PC;
        end else if (redirect) begin
            pc <= cf_i.target;                      // Wins over consume
        end else if (consume_i) begin
            pc <= npc_o;
        end
    end

    assign pc_o = pc;

endmodule

`default_nettype wire

/* source/rv_decode_stage.sv */
/*
 * Decode and operand gather stage top: fetch and execute handshake,
 * register file read, ALU operand selection and output assembly.
 */
`timescale 1ns/10ps
`default_nettype none

module rv_decode_stage (
    input  wire                              g_clk,
    input  wire                              g_resetn,
    input  wire rv_decode_pkg::fetch_t       fetch_i,     // From fetch
    output logic                             consume_o,   // Fetch may drop instr
    input  wire rv_decode_pkg::cf_redirect_t cf_i,        // From control flow
    output rv_decode_pkg::reg_addr_t         rs1_addr_o,  // Register file read
    output rv_decode_pkg::reg_addr_t         rs2_addr_o,
    input  wire rv_decode_pkg::word_t        rs1_data_i,
    input  wire rv_decode_pkg::word_t        rs2_data_i,
    input  wire                              ex_ready_i,  // Execute accepts
    output logic                             ex_valid_o,
    output rv_decode_pkg::decode_out_t       decode_o
);

    rv_decode_pkg::uop_t      uop;
    rv_decode_pkg::reg_addr_t rd;
    rv_decode_pkg::word_t     imm;
    rv_decode_pkg::word_t     pc;
    rv_decode_pkg::word_t     npc;

    // Handshake
    // ----------------------------------------
    assign ex_valid_o = fetch_i.valid;
    assign consume_o  = fetch_i.valid && ex_ready_i;    // Same cycle as transfer

    // Sub-blocks
    // ----------------------------------------
    rv_uop_decode rv_uop_decode_i (
        .instr_i (fetch_i.instr),
        .ferr_i  (fetch_i.ferr),
        .uop_o   (uop),
        .rs1_o   (rs1_addr_o),
        .rs2_o   (rs2_addr_o),
        .rd_o    (rd)
    );

    rv_imm_gen rv_imm_gen_i (
        .instr_i (fetch_i.instr),
        .fmt_i   (uop.imm_fmt),
        .imm_o   (imm)
    );

    rv_pc_track rv_pc_track_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_i      (cf_i),
        .consume_i (consume_o),
        .pc_o      (pc),
        .npc_o     (npc)
    );

    // Output assembly and operand muxes
    // ----------------------------------------
    always_comb begin
        decode_o.pc       = pc;
        decode_o.npc      = npc;
        decode_o.rd       = rd;
        decode_o.rs1_data = rs1_data_i;
        decode_o.rs2_data = rs2_data_i;
        decode_o.imm      = imm;
        decode_o.alu_lhs  = uop.lhs_pc  ? pc  : rs1_data_i;   // auipc
        decode_o.alu_rhs  = uop.rhs_imm ? imm : rs2_data_i;
        decode_o.uop      = uop;
    end

endmodule

`default_nettype wire

/* sim/rv_decode_assertions.sv */
/*
 * Concurrent checks on the decode stage, bound into rv_decode_stage:
 * consume handshake, PC advance on consume and PC hold when idle.
 */
`timescale 1ns/10ps
`default_nettype none

module rv_decode_assertions (
    input wire                       g_clk,
    input wire                       g_resetn,
    input wire                       fetch_valid_i,  // fetch_i.valid
    input wire                       ex_ready_i,
    input wire                       consume_i,
    input wire                       redirect_i,     // cf valid and ack
    input wire rv_decode_pkg::word_t pc_i
);

    int fail_count = 0;     // Read by the testbench summary

    consume_handshake: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        consume_i |-> (fetch_valid_i && ex_ready_i)
    ) else begin
        fail_count++;
        $error("consume without valid and ready");
    end

    pc_advance: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (consume_i && !redirect_i) |=> (pc_i == $past(pc_i) + 32'd4)
    ) else begin
        fail_count++;
        $error("PC did not advance by 4 after consume");
    end

    pc_hold: assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (!consume_i && !redirect_i) |=> $stable(pc_i)
    ) else begin
        fail_count++;
        $error("PC changed without consume or redirect");
    end

endmodule

`default_nettype wire

/* sim/rv_decode_tb.sv */
/*
 * Directed testbench for rv_decode_stage: clock, reset, watchdog,
 * register file model, PC reference model, typed compare tasks
 * and one task per tested behavior.
 */
`timescale 1ns/10ps
`default_nettype none

`include "rv_decode_macros.svh"

module rv_decode_tb;

    localparam int NUM_TESTS = 6;

    logic                             g_clk;
    logic                             g_resetn;
    rv_decode_pkg::fetch_t            fetch;
    rv_decode_pkg::cf_redirect_t      cf;
    rv_decode_pkg::cf_redirect_t      next_cf;      // Applied at next drive
    logic                             ex_ready;
    logic                             consume;
    logic                             ex_valid;
    rv_decode_pkg::reg_addr_t         rs1_addr;
    rv_decode_pkg::reg_addr_t         rs2_addr;
    rv_decode_pkg::word_t             rs1_data;
    rv_decode_pkg::word_t             rs2_data;
    rv_decode_pkg::decode_out_t       decode_out;
    rv_decode_pkg::word_t             exp_pc;
    int                               errors = 0;
    int                               tests_run = 0;
    int                               tests_failed = 0;
    int                               assert_errors;

    rv_decode_stage rv_decode_stage_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .fetch_i    (fetch),
        .consume_o  (consume),
        .cf_i       (cf),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_ready_i (ex_ready),
        .ex_valid_o (ex_valid),
        .decode_o   (decode_out)
    );

    bind rv_decode_stage rv_decode_assertions rv_decode_assertions_i (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .fetch_valid_i (fetch_i.valid),
        .ex_ready_i    (ex_ready_i),
        .consume_i     (consume_o),
        .redirect_i    (cf_i.valid && cf_i.ack),
        .pc_i          (decode_o.pc)
    );

    // Register file model, x0 included
    function automatic rv_decode_pkg::word_t reg_value(input rv_decode_pkg::reg_addr_t a);
        return rv_decode_pkg::word_t'(a) * 16 + 3;
    endfunction

    assign rs1_data = reg_value(rs1_addr);
    assign rs2_data = reg_value(rs2_addr);

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;         // 100 ns period
    end

    // Reference PC from the driven inputs
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            exp_pc <= `RV_RESET_PC;
        end else if (cf.valid && cf.ack) begin
            exp_pc <= cf.target;
        end else if (fetch.valid && ex_ready) begin
            exp_pc <= exp_pc + 32'd4;
        end
    end

    initial begin
        repeat (NUM_TESTS * 40) @(posedge g_clk);
        $display("Timeout: watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // Drive and compare
    // ----------------------------------------
    task automatic apply(input logic [31:0] instr, input logic valid, ferr, ready);
        @(negedge g_clk);
        fetch.instr = instr;
        fetch.valid = valid;
        fetch.ferr  = ferr;
        ex_ready    = ready;
        cf          = next_cf;
        next_cf     = '0;
        #10;                                // Let the decode settle
    endtask

    task automatic report_mismatch(input string what, input string got, input string exp);
        errors++;
        $display("FAILED %0t: %s is %s, expected %s", $time, what, got, exp);
    endtask

    task automatic check_word(input string what, input rv_decode_pkg::word_t got, exp);
        if (got !== exp) begin
            report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, exp);
        if (got !== exp) begin
            report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
        end
    endtask

    task automatic check_reg(input string what, input rv_decode_pkg::reg_addr_t got, exp);
        if (got !== exp) begin
            report_mismatch(what, $sformatf("x%0d", got), $sformatf("x%0d", exp));
        end
    endtask

    task automatic check_alu(input string what, input rv_decode_pkg::alu_op_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic check_cfu(input string what, input rv_decode_pkg::cfu_op_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic check_lsu(input string what, input rv_decode_pkg::lsu_op_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic check_width(input string what, input rv_decode_pkg::lsu_width_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic check_fmt(input string what, input rv_decode_pkg::imm_fmt_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic check_wb(input string what, input rv_decode_pkg::wb_sel_e got, exp);
        if (got !== exp) begin
            report_mismatch(what, got.name(), exp.name());
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Tests
    // ----------------------------------------
    task automatic test_reset();
        int start;
        start = errors;
        apply(32'h0000_0013, 1'b0, 1'b0, 1'b1);
        check_word("pc after reset", decode_out.pc, `RV_RESET_PC);
        check_word("npc after reset", decode_out.npc, `RV_RESET_PC + 32'd4);
        check_bit("consume while idle", consume, 1'b0);
        check_bit("ex_valid while idle", ex_valid, 1'b0);
        end_test("reset", start);
    endtask

    task automatic alu_case(input logic [31:0] instr, input rv_decode_pkg::alu_op_e op,
                            input rv_decode_pkg::reg_addr_t rd, rs1, rs2,
                            input logic use_imm, input rv_decode_pkg::word_t imm);
        apply(instr, 1'b1, 1'b0, 1'b1);
        check_bit("ex_valid", ex_valid, 1'b1);
        check_alu("alu_op", decode_out.uop.alu_op, op);
        check_reg("rd", decode_out.rd, rd);
        check_reg("rs1_addr", rs1_addr, rs1);
        check_word("rs1_data", decode_out.rs1_data, reg_value(rs1));
        if (!use_imm) begin
            check_reg("rs2_addr", rs2_addr, rs2);
            check_word("rs2_data", decode_out.rs2_data, reg_value(rs2));
        end
        check_word("alu_lhs", decode_out.alu_lhs, reg_value(rs1));
        check_word("alu_rhs", decode_out.alu_rhs, use_imm ? imm : reg_value(rs2));
        check_wb("wb_sel", decode_out.uop.wb_sel, rv_decode_pkg::wb_alu);
    endtask

    task automatic test_alu();
        int start;
        start = errors;
        alu_case(enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd5), rv_decode_pkg::alu_add,
                 5'd5, 5'd6, 5'd7, 1'b0, '0);
        alu_case(enc_r(7'h20, 5'd10, 5'd9, 3'b000, 5'd8), rv_decode_pkg::alu_sub,
                 5'd8, 5'd9, 5'd10, 1'b0, '0);
        alu_case(enc_i(12'hFFB, 5'd12, 3'b100, 5'd11, `RV_OP_IMM), rv_decode_pkg::alu_xor,
                 5'd11, 5'd12, 5'd0, 1'b1, 32'hFFFF_FFFB);
        alu_case(enc_i(12'h407, 5'd14, 3'b101, 5'd13, `RV_OP_IMM), rv_decode_pkg::alu_sra,
                 5'd13, 5'd14, 5'd0, 1'b1, 32'h0000_0407);
        alu_case(enc_r(7'h00, 5'd17, 5'd16, 3'b011, 5'd15), rv_decode_pkg::alu_sltu,
                 5'd15, 5'd16, 5'd17, 1'b0, '0);
        end_test("alu", start);
    endtask

    task automatic test_imm();
        int start;
        start = errors;
        apply(enc_s(12'hFF4, 5'd20, 5'd21, 3'b010), 1'b1, 1'b0, 1'b1);   // sw
        check_fmt("sw fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_s);
        check_word("sw imm", decode_out.imm, 32'hFFFF_FFF4);
        check_lsu("sw lsu", decode_out.uop.lsu_op, rv_decode_pkg::lsu_store);
        check_width("sw width", decode_out.uop.lsu_width, rv_decode_pkg::lsu_word);
        check_wb("sw wb", decode_out.uop.wb_sel, rv_decode_pkg::wb_none);
        apply(enc_i(12'h7FF, 5'd4, 3'b100, 5'd3, `RV_OP_LOAD), 1'b1, 1'b0, 1'b1);  // lbu
        check_fmt("lbu fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_i);
        check_word("lbu imm", decode_out.imm, 32'h0000_07FF);
        check_lsu("lbu lsu", decode_out.uop.lsu_op, rv_decode_pkg::lsu_load);
        check_bit("lbu sext", decode_out.uop.lsu_sext, 1'b0);
        check_wb("lbu wb", decode_out.uop.wb_sel, rv_decode_pkg::wb_lsu);
        apply({20'hABCDE, 5'd6, `RV_OP_LUI}, 1'b1, 1'b0, 1'b1);
        check_fmt("lui fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_u);
        check_word("lui imm", decode_out.imm, 32'hABCD_E000);
        check_alu("lui alu", decode_out.uop.alu_op, rv_decode_pkg::alu_or);
        check_reg("lui rs1", rs1_addr, 5'd0);
        apply({20'h00012, 5'd7, `RV_OP_AUIPC}, 1'b1, 1'b0, 1'b1);
        check_fmt("auipc fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_u);
        check_word("auipc imm", decode_out.imm, 32'h0001_2000);
        check_word("auipc alu_lhs", decode_out.alu_lhs, exp_pc);
        apply(enc_b(13'h1FF0, 5'd2, 5'd1, 3'b000), 1'b1, 1'b0, 1'b1);    // beq
        check_fmt("beq fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_b);
        check_word("beq imm", decode_out.imm, 32'hFFFF_FFF0);
        check_cfu("beq cfu", decode_out.uop.cfu_op, rv_decode_pkg::cfu_beq);
        check_wb("beq wb", decode_out.uop.wb_sel, rv_decode_pkg::wb_none);
        apply(enc_j(21'h1F2B44, 5'd1), 1'b1, 1'b0, 1'b1);                 // jal
        check_fmt("jal fmt", decode_out.uop.imm_fmt, rv_decode_pkg::imm_j);
        check_word("jal imm", decode_out.imm, 32'hFFFF_2B44);
        check_cfu("jal cfu", decode_out.uop.cfu_op, rv_decode_pkg::cfu_jal);
        check_wb("jal wb", decode_out.uop.wb_sel, rv_decode_pkg::wb_npc);
        end_test("immediates", start);
    endtask

    task automatic test_backpressure();
        int                   start;
        rv_decode_pkg::word_t base;
        start = errors;
        base  = '0;
        for (int k = 0; k < 5; k++) begin
            apply(32'h0010_0093, 1'b1, 1'b0, 1'b0);   // addi x1, x0, 1
            if (k == 0) begin
                base = exp_pc;                      // Earlier consume has landed
            end
            check_bit("consume while stalled", consume, 1'b0);
            check_word("pc while stalled", decode_out.pc, base);
        end
        for (int k = 0; k < 4; k++) begin
            apply(32'h0010_0093, 1'b1, 1'b0, 1'b1);
            check_bit("consume when ready", consume, 1'b1);
            check_word("pc when ready", decode_out.pc, base + 32'd4 * k);
        end
        end_test("backpressure", start);
    endtask

    task automatic test_redirect();
        int                   start;
        rv_decode_pkg::word_t base;
        start   = errors;
        next_cf = '{valid: 1'b1, ack: 1'b1, target: 32'h2000_0040};
        apply(32'h0010_0093, 1'b1, 1'b0, 1'b1);       // Consume on same edge
        check_bit("consume with redirect", consume, 1'b1);
        apply(32'h0010_0093, 1'b0, 1'b0, 1'b1);
        check_word("pc after redirect", decode_out.pc, 32'h2000_0040);
        base    = exp_pc;
        next_cf = '{valid: 1'b1, ack: 1'b0, target: 32'h3000_0000};
        apply(32'h0010_0093, 1'b1, 1'b0, 1'b1);       // No ack, so no redirect
        apply(32'h0010_0093, 1'b0, 1'b0, 1'b1);
        check_word("pc without ack", decode_out.pc, base + 32'd4);
        end_test("redirect", start);
    endtask

    task automatic test_trap();
        int start;
        start = errors;
        apply(32'h0000_007F, 1'b1, 1'b0, 1'b1);       // Unknown opcode
        check_bit("trap on illegal opcode", decode_out.uop.trap, 1'b1);
        check_wb("wb on illegal opcode", decode_out.uop.wb_sel, rv_decode_pkg::wb_none);
        apply(32'h0010_0093, 1'b1, 1'b1, 1'b1);       // addi with bus error
        check_bit("trap on fetch error", decode_out.uop.trap, 1'b1);
        check_wb("wb on fetch error", decode_out.uop.wb_sel, rv_decode_pkg::wb_none);
        apply(32'h0010_0093, 1'b1, 1'b0, 1'b1);
        check_bit("trap on legal addi", decode_out.uop.trap, 1'b0);
        end_test("trap", start);
    endtask

    initial begin
        fetch    = '0;
        cf       = '0;
        next_cf  = '0;
        ex_ready = 1'b0;
        g_resetn = 1'b0;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        test_reset();
        test_alu();
        test_imm();
        test_backpressure();
        test_redirect();
        test_trap();
        apply(32'h0000_0013, 1'b0, 1'b0, 1'b0);
        assert_errors = rv_decode_stage_i.rv_decode_assertions_i.fail_count;
        $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion errors: %0d",
                 tests_run, tests_failed, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/rv_decode_pkg.sv
source/rv_imm_gen.sv
source/rv_uop_decode.sv
source/rv_pc_track.sv
source/rv_decode_stage.sv
sim/rv_decode_assertions.sv
sim/rv_decode_tb.sv
